// ==== common/rv_pkg.sv ====
package rv_pkg;

  localparam int XLEN  = 32; // data and address width
  localparam int REG_W = 5;  // register index width

  // decoded operation
  // immediate ALU forms share the register op code, use_imm tells them apart
  typedef enum logic [4:0] {
    OP_INVALID = 5'd0,
    OP_LUI     = 5'd1,
    OP_AUIPC   = 5'd2,
    OP_JAL     = 5'd3,
    OP_JALR    = 5'd4,
    // conditional branches
    OP_BEQ     = 5'd5,
    OP_BNE     = 5'd6,
    OP_BLT     = 5'd7,
    OP_BGE     = 5'd8,
    OP_BLTU    = 5'd9,
    OP_BGEU    = 5'd10,
    // loads
    OP_LB      = 5'd11,
    OP_LH      = 5'd12,
    OP_LW      = 5'd13,
    OP_LBU     = 5'd14,
    OP_LHU     = 5'd15,
    // stores
    OP_SB      = 5'd16,
    OP_SH      = 5'd17,
    OP_SW      = 5'd18,
    // integer ALU
    OP_ADD     = 5'd19,
    OP_SUB     = 5'd20, // no immediate form
    OP_SLL     = 5'd21,
    OP_SLT     = 5'd22,
    OP_SLTU    = 5'd23,
    OP_XOR     = 5'd24,
    OP_SRL     = 5'd25,
    OP_SRA     = 5'd26,
    OP_OR      = 5'd27,
    OP_AND     = 5'd28
  } op_e;

  // issue target
  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_LSU = 2'd1,
    UNIT_BR  = 2'd2
  } unit_e;

  // stores write memory, not the register file
  function automatic logic op_is_store(op_e op);
    return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
  endfunction

endpackage

// ==== rtl/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
  input  logic [rv_pkg::XLEN-1:0]  inst_word,
  input  logic [rv_pkg::XLEN-1:0]  inst_addr,
  output rv_pkg::op_e              op,
  output logic [rv_pkg::REG_W-1:0] rd,
  output logic [rv_pkg::REG_W-1:0] rs1,
  output logic [rv_pkg::REG_W-1:0] rs2,
  output logic [rv_pkg::XLEN-1:0]  imm,
  output logic                     branch,
  output logic                     ls,
  output logic                     use_imm,
  output logic                     jalr,
  output logic [rv_pkg::XLEN-1:0]  addr
);
  import rv_pkg::*;

  // RV32I major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_REG    = 7'b0110011;

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [REG_W-1:0] f_rd;
  logic [REG_W-1:0] f_rs1;
  logic [REG_W-1:0] f_rs2;
  logic [XLEN-1:0]  imm_i;
  logic [XLEN-1:0]  imm_s;
  logic [XLEN-1:0]  imm_b;
  logic [XLEN-1:0]  imm_u;
  logic [XLEN-1:0]  imm_j;
  logic [XLEN-1:0]  imm_sh;

  assign opcode = inst_word[6:0];
  assign funct3 = inst_word[14:12];
  assign funct7 = inst_word[31:25];
  assign f_rd   = inst_word[11:7];
  assign f_rs1  = inst_word[19:15];
  assign f_rs2  = inst_word[24:20];

  // immediates by format, all sign extended from bit 31
  assign imm_i  = {{20{inst_word[31]}}, inst_word[31:20]};
  assign imm_s  = {{20{inst_word[31]}}, inst_word[31:25], inst_word[11:7]};
  assign imm_b  = {{19{inst_word[31]}}, inst_word[31], inst_word[7],
                   inst_word[30:25], inst_word[11:8], 1'b0};
  assign imm_u  = {inst_word[31:12], 12'b0};
  assign imm_j  = {{11{inst_word[31]}}, inst_word[31], inst_word[19:12],
                   inst_word[20], inst_word[30:21], 1'b0};
  assign imm_sh = {{(XLEN-5){1'b0}}, inst_word[24:20]}; // shamt only

  always_comb begin
    op      = OP_INVALID;
    rd      = '0;
    rs1     = '0;
    rs2     = '0;
    imm     = '0;
    branch  = 1'b0;
    ls      = 1'b0;
    use_imm = 1'b0;
    jalr    = 1'b0;
    case (opcode)
      OPC_LUI: begin
        op = OP_LUI; rd = f_rd; imm = imm_u; use_imm = 1'b1;
      end
      OPC_AUIPC: begin
        op = OP_AUIPC; rd = f_rd; imm = imm_u; use_imm = 1'b1;
      end
      OPC_JAL: begin
        op = OP_JAL; rd = f_rd; imm = imm_j; branch = 1'b1;
      end
      OPC_JALR: begin
        rd = f_rd; rs1 = f_rs1; imm = imm_i; use_imm = 1'b1;
        branch = 1'b1;
        jalr = 1'b1;
        if (funct3 == 3'b000) op = OP_JALR;
      end
      OPC_BRANCH: begin
        rs1 = f_rs1; rs2 = f_rs2; imm = imm_b; branch = 1'b1;
        case (funct3)
          3'b000:  op = OP_BEQ;
          3'b001:  op = OP_BNE;
          3'b100:  op = OP_BLT;
          3'b101:  op = OP_BGE;
          3'b110:  op = OP_BLTU;
          3'b111:  op = OP_BGEU;
          default: op = OP_INVALID;
        endcase
      end
      OPC_LOAD: begin
        rd = f_rd; rs1 = f_rs1; imm = imm_i; ls = 1'b1; use_imm = 1'b1;
        case (funct3)
          3'b000:  op = OP_LB;
          3'b001:  op = OP_LH;
          3'b010:  op = OP_LW;
          3'b100:  op = OP_LBU;
          3'b101:  op = OP_LHU;
          default: op = OP_INVALID;
        endcase
      end
      OPC_STORE: begin
        rs1 = f_rs1; rs2 = f_rs2; imm = imm_s; ls = 1'b1; // rs2 is store data
        case (funct3)
          3'b000:  op = OP_SB;
          3'b001:  op = OP_SH;
          3'b010:  op = OP_SW;
          default: op = OP_INVALID;
        endcase
      end
      OPC_IMM: begin
        rd = f_rd; rs1 = f_rs1; imm = imm_i; use_imm = 1'b1;
        case (funct3)
          3'b000: op = OP_ADD;
          3'b010: op = OP_SLT;
          3'b011: op = OP_SLTU;
          3'b100: op = OP_XOR;
          3'b110: op = OP_OR;
          3'b111: op = OP_AND;
          3'b001: begin
            imm = imm_sh;
            if (funct7 == 7'b0000000) op = OP_SLL;
          end
          default: begin // 3'b101, logical or arithmetic right shift
            imm = imm_sh;
            if (funct7 == 7'b0000000) op = OP_SRL;
            else if (funct7 == 7'b0100000) op = OP_SRA;
          end
        endcase
      end
      OPC_REG: begin
        rd = f_rd; rs1 = f_rs1; rs2 = f_rs2;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: op = OP_ADD;
          {7'b0100000, 3'b000}: op = OP_SUB;
          {7'b0000000, 3'b001}: op = OP_SLL;
          {7'b0000000, 3'b010}: op = OP_SLT;
          {7'b0000000, 3'b011}: op = OP_SLTU;
          {7'b0000000, 3'b100}: op = OP_XOR;
          {7'b0000000, 3'b101}: op = OP_SRL;
          {7'b0100000, 3'b101}: op = OP_SRA;
          {7'b0000000, 3'b110}: op = OP_OR;
          {7'b0000000, 3'b111}: op = OP_AND;
          default:              op = OP_INVALID;
        endcase
      end
      default: op = OP_INVALID;
    endcase

    // illegal word carries no fields downstream
    if (op == OP_INVALID) begin
      rd      = '0;
      rs1     = '0;
      rs2     = '0;
      imm     = '0;
      branch  = 1'b0;
      ls      = 1'b0;
      use_imm = 1'b0;
      jalr    = 1'b0;
    end
  end

  assign addr = inst_addr;

endmodule

// ==== op_queue/fetched_op_queue.sv ====
`timescale 1ns/1ps

module fetched_op_queue #(
  parameter int DEPTH = 8
) (
  input  logic                     clk_in,
  input  logic                     arst_n,
  input  logic                     rdy,
  input  logic                     predict_fail,
  input  logic                     push,
  input  rv_pkg::op_e              op,
  input  logic [rv_pkg::REG_W-1:0] rd,
  input  logic [rv_pkg::REG_W-1:0] rs1,
  input  logic [rv_pkg::REG_W-1:0] rs2,
  input  logic [rv_pkg::XLEN-1:0]  imm,
  input  logic                     branch,
  input  logic                     ls,
  input  logic                     use_imm,
  input  logic                     jalr,
  input  logic [rv_pkg::XLEN-1:0]  addr,
  output rv_pkg::op_e              head_op,
  output logic [rv_pkg::REG_W-1:0] head_rd,
  output logic [rv_pkg::REG_W-1:0] head_rs1,
  output logic [rv_pkg::REG_W-1:0] head_rs2,
  output logic [rv_pkg::XLEN-1:0]  head_imm,
  output logic                     head_branch,
  output logic                     head_ls,
  output logic                     head_use_imm,
  output logic                     head_jalr,
  output logic [rv_pkg::XLEN-1:0]  head_addr,
  output logic                     head_valid,
  output logic                     queue_full
);
  import rv_pkg::*;

  localparam int IDX_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int OP_W    = $bits(op_e);
  localparam int ENTRY_W = OP_W + 3 * REG_W + 2 * XLEN + 4;

  logic [ENTRY_W-1:0] mem [DEPTH];
  logic [IDX_W-1:0]   front;
  logic [IDX_W-1:0]   rear;
  logic [IDX_W-1:0]   front_nxt;
  logic [IDX_W-1:0]   rear_nxt;
  logic [ENTRY_W-1:0] push_entry;
  logic [ENTRY_W-1:0] head_entry;
  logic [OP_W-1:0]    head_op_raw;
  logic               do_push;
  logic               do_pop;

  // pointers wrap at DEPTH-1
  assign front_nxt = (front == IDX_W'(DEPTH - 1)) ? '0 : front + 1'b1;
  assign rear_nxt  = (rear == IDX_W'(DEPTH - 1)) ? '0 : rear + 1'b1;

  assign head_valid = (front != rear);
  assign queue_full = (rear_nxt == front); // one slot always left spare

  assign do_push = rdy && push && !queue_full;
  assign do_pop  = rdy && head_valid;

  assign push_entry = {op, rd, rs1, rs2, imm, branch, ls, use_imm, jalr, addr};
  assign head_entry = head_valid ? mem[front] : '0; // zeros when empty

  assign {head_op_raw, head_rd, head_rs1, head_rs2, head_imm,
          head_branch, head_ls, head_use_imm, head_jalr, head_addr} = head_entry;
  assign head_op = op_e'(head_op_raw);

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      front <= '0;
      rear  <= '0;
    end else if (predict_fail) begin // flush wins over pause
      front <= '0;
      rear  <= '0;
    end else begin
      if (do_pop) front <= front_nxt;
      if (do_push) rear <= rear_nxt;
    end
  end

  // entry storage
  always_ff @(posedge clk_in) begin
    if (do_push) mem[rear] <= push_entry;
  end

endmodule

// ==== rtl/issue_router.sv ====
`timescale 1ns/1ps

module issue_router (
  input  logic                     clk_in,
  input  logic                     arst_n,
  input  logic                     rdy,
  input  logic                     predict_fail,
  input  logic                     head_valid,
  input  rv_pkg::op_e              head_op,
  input  logic [rv_pkg::REG_W-1:0] head_rd,
  input  logic [rv_pkg::REG_W-1:0] head_rs1,
  input  logic [rv_pkg::REG_W-1:0] head_rs2,
  input  logic [rv_pkg::XLEN-1:0]  head_imm,
  input  logic                     head_branch,
  input  logic                     head_ls,
  input  logic                     head_use_imm,
  input  logic                     head_jalr,
  input  logic [rv_pkg::XLEN-1:0]  head_addr,
  output logic                     alu_issue,
  output logic                     lsu_issue,
  output logic                     br_issue,
  output rv_pkg::op_e              issue_op,
  output logic [rv_pkg::REG_W-1:0] issue_rd,
  output logic [rv_pkg::REG_W-1:0] issue_rs1,
  output logic [rv_pkg::REG_W-1:0] issue_rs2,
  output logic [rv_pkg::XLEN-1:0]  issue_imm,
  output logic [rv_pkg::XLEN-1:0]  issue_addr,
  output logic [rv_pkg::XLEN-1:0]  link_value,
  output logic                     issue_use_imm,
  output logic                     issue_rd_we
);
  import rv_pkg::*;

  unit_e unit;
  logic  pop;
  logic  op_ok;
  logic  cond_br;
  logic  rd_we;

  assign pop   = rdy && head_valid; // same pop rule as the queue
  assign op_ok = (head_op != OP_INVALID);

  // branch beats ls beats alu
  always_comb begin
    if (head_branch) unit = UNIT_BR;
    else if (head_ls) unit = UNIT_LSU;
    else unit = UNIT_ALU;
  end

  // jumps link, conditional branches do not
  assign cond_br = head_branch && !head_jalr && (head_op != OP_JAL);
  assign rd_we   = (head_rd != '0) && !op_is_store(head_op) && !cond_br;

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      alu_issue <= 1'b0;
      lsu_issue <= 1'b0;
      br_issue  <= 1'b0;
    end else if (predict_fail) begin
      alu_issue <= 1'b0;
      lsu_issue <= 1'b0;
      br_issue  <= 1'b0;
    end else if (rdy) begin // strobes hold while paused
      alu_issue <= pop && op_ok && (unit == UNIT_ALU);
      lsu_issue <= pop && op_ok && (unit == UNIT_LSU);
      br_issue  <= pop && op_ok && (unit == UNIT_BR);
    end
  end

  // issue payload, loaded on each pop
  always_ff @(posedge clk_in) begin
    if (pop && !predict_fail) begin
      issue_op      <= head_op;
      issue_rd      <= head_rd;
      issue_rs1     <= head_rs1;
      issue_rs2     <= head_rs2;
      issue_imm     <= head_imm;
      issue_addr    <= head_addr;
      issue_use_imm <= head_use_imm;
      issue_rd_we   <= rd_we;
    end
  end

  assign link_value = issue_addr + XLEN'(4); // return address

endmodule

// ==== rtl/decode_issue_top.sv ====
`timescale 1ns/1ps

module decode_issue_top #(
  parameter int DEPTH = 8
) (
  input  logic                     clk_in,
  input  logic                     arst_n,
  input  logic                     rdy,
  input  logic                     predict_fail,
  input  logic                     inst_valid,
  input  logic [rv_pkg::XLEN-1:0]  inst_word,
  input  logic [rv_pkg::XLEN-1:0]  inst_addr,
  output logic                     fetch_stall,
  output logic                     alu_issue,
  output logic                     lsu_issue,
  output logic                     br_issue,
  output rv_pkg::op_e              issue_op,
  output logic [rv_pkg::REG_W-1:0] issue_rd,
  output logic [rv_pkg::REG_W-1:0] issue_rs1,
  output logic [rv_pkg::REG_W-1:0] issue_rs2,
  output logic [rv_pkg::XLEN-1:0]  issue_imm,
  output logic [rv_pkg::XLEN-1:0]  issue_addr,
  output logic [rv_pkg::XLEN-1:0]  link_value,
  output logic                     issue_use_imm,
  output logic                     issue_rd_we
);
  import rv_pkg::*;

  // decoder outputs
  op_e              dec_op;
  logic [REG_W-1:0] dec_rd;
  logic [REG_W-1:0] dec_rs1;
  logic [REG_W-1:0] dec_rs2;
  logic [XLEN-1:0]  dec_imm;
  logic             dec_branch;
  logic             dec_ls;
  logic             dec_use_imm;
  logic             dec_jalr;
  logic [XLEN-1:0]  dec_addr;

  // queue head
  op_e              head_op;
  logic [REG_W-1:0] head_rd;
  logic [REG_W-1:0] head_rs1;
  logic [REG_W-1:0] head_rs2;
  logic [XLEN-1:0]  head_imm;
  logic             head_branch;
  logic             head_ls;
  logic             head_use_imm;
  logic             head_jalr;
  logic [XLEN-1:0]  head_addr;
  logic             head_valid;

  inst_decoder u_decoder (
    .inst_word (inst_word),
    .inst_addr (inst_addr),
    .op        (dec_op),
    .rd        (dec_rd),
    .rs1       (dec_rs1),
    .rs2       (dec_rs2),
    .imm       (dec_imm),
    .branch    (dec_branch),
    .ls        (dec_ls),
    .use_imm   (dec_use_imm),
    .jalr      (dec_jalr),
    .addr      (dec_addr)
  );

  fetched_op_queue #(
    .DEPTH (DEPTH)
  ) u_queue (
    .clk_in       (clk_in),
    .arst_n       (arst_n),
    .rdy          (rdy),
    .predict_fail (predict_fail),
    .push         (inst_valid),
    .op           (dec_op),
    .rd           (dec_rd),
    .rs1          (dec_rs1),
    .rs2          (dec_rs2),
    .imm          (dec_imm),
    .branch       (dec_branch),
    .ls           (dec_ls),
    .use_imm      (dec_use_imm),
    .jalr         (dec_jalr),
    .addr         (dec_addr),
    .head_op      (head_op),
    .head_rd      (head_rd),
    .head_rs1     (head_rs1),
    .head_rs2     (head_rs2),
    .head_imm     (head_imm),
    .head_branch  (head_branch),
    .head_ls      (head_ls),
    .head_use_imm (head_use_imm),
    .head_jalr    (head_jalr),
    .head_addr    (head_addr),
    .head_valid   (head_valid),
    .queue_full   (fetch_stall) // fetch holds its word while full
  );

  issue_router u_router (
    .clk_in        (clk_in),
    .arst_n        (arst_n),
    .rdy           (rdy),
    .predict_fail  (predict_fail),
    .head_valid    (head_valid),
    .head_op       (head_op),
    .head_rd       (head_rd),
    .head_rs1      (head_rs1),
    .head_rs2      (head_rs2),
    .head_imm      (head_imm),
    .head_branch   (head_branch),
    .head_ls       (head_ls),
    .head_use_imm  (head_use_imm),
    .head_jalr     (head_jalr),
    .head_addr     (head_addr),
    .alu_issue     (alu_issue),
    .lsu_issue     (lsu_issue),
    .br_issue      (br_issue),
    .issue_op      (issue_op),
    .issue_rd      (issue_rd),
    .issue_rs1     (issue_rs1),
    .issue_rs2     (issue_rs2),
    .issue_imm     (issue_imm),
    .issue_addr    (issue_addr),
    .link_value    (link_value),
    .issue_use_imm (issue_use_imm),
    .issue_rd_we   (issue_rd_we)
  );

endmodule

// ==== verif/decode_issue_assertions.sv ====
`timescale 1ns/1ps

module decode_issue_assertions #(
  parameter int IDX_W = 3
) (
  input logic             clk_in,
  input logic             arst_n,
  input logic             rdy,
  input logic             predict_fail,
  input logic             alu_issue,
  input logic             lsu_issue,
  input logic             br_issue,
  input logic             queue_full,
  input logic [IDX_W-1:0] rear
);

  // one issue port per cycle at most
  a_one_strobe: assert property (@(posedge clk_in) disable iff (!arst_n)
    $onehot0({alu_issue, lsu_issue, br_issue}))
    else $error("more than one issue strobe high");

  a_flush_clears: assert property (@(posedge clk_in) disable iff (!arst_n)
    predict_fail |=> !(alu_issue || lsu_issue || br_issue))
    else $error("issue strobe high in the cycle after a flush");

  // a full queue takes no push
  a_full_hold: assert property (@(posedge clk_in) disable iff (!arst_n)
    (queue_full && rdy && !predict_fail) |=> $stable(rear))
    else $error("rear pointer moved while the queue was full");

endmodule

bind fetched_op_queue decode_issue_assertions #(.IDX_W(IDX_W)) queue_checks (
  .clk_in       (clk_in),
  .arst_n       (arst_n),
  .rdy          (rdy),
  .predict_fail (predict_fail),
  .alu_issue    (1'b0),
  .lsu_issue    (1'b0),
  .br_issue     (1'b0),
  .queue_full   (queue_full),
  .rear         (rear)
);

bind issue_router decode_issue_assertions router_checks (
  .clk_in       (clk_in),
  .arst_n       (arst_n),
  .rdy          (rdy),
  .predict_fail (predict_fail),
  .alu_issue    (alu_issue),
  .lsu_issue    (lsu_issue),
  .br_issue     (br_issue),
  .queue_full   (1'b0),
  .rear         ('0)
);

// ==== verif/tb_decode_issue.sv ====
`timescale 1ns/1ps

module tb_decode_issue;
  import rv_pkg::*;

  localparam int DEPTH      = 8;
  localparam int NV         = 24;  // vectors in the file
  localparam int NF         = 10;  // words per vector
  localparam int FLUSH_AT   = 12;  // vector that gets flushed
  localparam int MAX_CYCLES = 8 * NV + 200;

  logic             clk_in = 1'b0;
  logic             arst_n;
  logic             rdy;
  logic             predict_fail;
  logic             inst_valid;
  logic [XLEN-1:0]  inst_word;
  logic [XLEN-1:0]  inst_addr;
  logic             fetch_stall;
  logic             alu_issue;
  logic             lsu_issue;
  logic             br_issue;
  op_e              issue_op;
  logic [REG_W-1:0] issue_rd;
  logic [REG_W-1:0] issue_rs1;
  logic [REG_W-1:0] issue_rs2;
  logic [XLEN-1:0]  issue_imm;
  logic [XLEN-1:0]  issue_addr;
  logic [XLEN-1:0]  link_value;
  logic             issue_use_imm;
  logic             issue_rd_we;

  logic [31:0] vec [NV*NF];
  int          sb[$];       // vector indices waiting for issue in push order
  int          errors;
  int          issued;
  int          flushed;
  int          n_invalid;
  int          cycles;
  int          vi;          // next vector offered by fetch
  int          occ;         // modelled queue occupancy
  logic [31:0] rng;
  logic        offer_taken;
  logic        prev_rdy;
  logic        prev_flush;

  always #10 clk_in = ~clk_in;

  decode_issue_top #(.DEPTH(DEPTH)) dut0 (.*);

  always @(posedge clk_in) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // compare one observed strobe with the oldest pending vector
  task automatic observe_issue();
    int          base;
    logic [31:0] got_unit;
    if (alu_issue || lsu_issue || br_issue) begin
      assert (sb.size() > 0) else begin
        $display("error at %0t: issue strobe with no op pending", $time);
        errors++;
      end
      if (sb.size() > 0) begin
        base     = sb.pop_front() * NF;
        got_unit = br_issue ? 32'd2 : (lsu_issue ? 32'd1 : 32'd0);
        check_val("unit", got_unit, vec[base+2]);
        check_val("issue_op", 32'(issue_op), vec[base+3]);
        check_val("issue_rd", 32'(issue_rd), vec[base+4]);
        check_val("issue_rs1", 32'(issue_rs1), vec[base+5]);
        check_val("issue_rs2", 32'(issue_rs2), vec[base+6]);
        check_val("issue_imm", issue_imm, vec[base+7]);
        check_val("issue_use_imm", 32'(issue_use_imm), vec[base+8]);
        check_val("issue_rd_we", 32'(issue_rd_we), vec[base+9]);
        check_val("issue_addr", issue_addr, vec[base+1]);
        check_val("link_value", link_value, vec[base+1] + 32'd4); // return address
        issued++;
      end
    end
  endtask

  // account for the last rising edge and drive the next one
  task automatic cycle_step(input logic flush_now, input logic force_rdy);
    if (prev_flush) begin
      flushed += sb.size();
      sb.delete();
      occ = 0;
    end else if (prev_rdy) begin
      observe_issue();
      if (occ > 0) occ--;
    end
    if (offer_taken) begin
      if (vec[vi*NF+2] == 32'd3) n_invalid++;
      else sb.push_back(vi);
      vi++;
      occ++;
    end
    rng          = xorshift32(rng);
    rdy          = (force_rdy || flush_now) ? 1'b1 : (rng[1:0] != 2'b00);
    predict_fail = flush_now;
    inst_valid   = (vi < NV);
    inst_word    = (vi < NV) ? vec[vi*NF] : '0;
    inst_addr    = (vi < NV) ? vec[vi*NF+1] : '0;
    #1;
    check_val("fetch_stall", 32'(fetch_stall), 32'(occ == DEPTH - 1));
    offer_taken = inst_valid && rdy && !predict_fail && (occ != DEPTH - 1);
    prev_rdy    = rdy;
    prev_flush  = predict_fail;
    @(negedge clk_in);
  endtask

  initial begin
    errors       = 0;
    issued       = 0;
    flushed      = 0;
    n_invalid    = 0;
    cycles       = 0;
    vi           = 0;
    occ          = 0;
    rng          = 32'd7;
    offer_taken  = 1'b0;
    prev_rdy     = 1'b0;
    prev_flush   = 1'b0;
    arst_n       = 1'b0;
    rdy          = 1'b0;
    predict_fail = 1'b0;
    inst_valid   = 1'b0;
    inst_word    = '0;
    inst_addr    = '0;
    $readmemh("verif/issue_vectors.txt", vec);

    repeat (8) @(posedge clk_in);
    @(negedge clk_in);
    arst_n = 1'b1;
    check_val("fetch_stall", 32'(fetch_stall), 32'd0);
    check_val("strobes", {29'd0, alu_issue, lsu_issue, br_issue}, 32'd0);

    // fetch offers with rdy low and nothing enters or issues
    inst_valid = 1'b1;
    inst_word  = vec[0];
    inst_addr  = vec[1];
    repeat (DEPTH + 2) begin
      @(negedge clk_in);
      check_val("fetch_stall", 32'(fetch_stall), 32'd0);
      check_val("strobes", {29'd0, alu_issue, lsu_issue, br_issue}, 32'd0);
    end

    while (vi < NV) begin
      if (vi == FLUSH_AT && flushed == 0 && !prev_flush) begin
        cycle_step(1'b0, 1'b1);  // push the victim op
        cycle_step(1'b1, 1'b1);
      end else begin
        cycle_step(1'b0, 1'b0);
      end
    end
    while (sb.size() > 0 || occ > 0 || offer_taken || prev_flush)
      cycle_step(1'b0, 1'b1);

    $display("summary: %0d issued, %0d flushed, %0d illegal, %0d errors",
             issued, flushed, n_invalid, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== verif/issue_vectors.txt ====
// columns: inst_word inst_addr unit op rd rs1 rs2 imm use_imm rd_we (all hex)
// unit 0 alu, 1 lsu, 2 branch, 3 none for an illegal word
002081B3 00001000 0 13 03 01 02 00000000 0 1
407302B3 00001004 0 14 05 06 07 00000000 0 1
FFF00513 00001008 0 13 0A 00 00 FFFFFFFF 1 1
00321213 0000100C 0 15 04 04 00 00000003 1 1
41F4D413 00001010 0 1A 08 09 00 0000001F 1 1
00812583 00001014 1 0D 0B 02 00 00000008 1 1
FFC0C003 00001018 1 0E 00 01 00 FFFFFFFC 1 0
0051A623 0000101C 1 12 00 03 05 0000000C 0 0
FE639F23 00001020 1 11 00 07 06 FFFFFFFE 0 0
00208863 00001024 2 05 00 01 02 00000010 0 0
FE419CE3 00001028 2 06 00 03 04 FFFFFFF8 0 0
0062F263 0000102C 2 0A 00 05 06 00000004 0 0
001000EF 00001030 2 03 01 00 00 00000800 0 1
FFDFF06F 00001034 2 03 00 00 00 FFFFFFFC 0 0
004280E7 00001038 2 04 01 05 00 00000004 1 1
123453B7 0000103C 0 01 07 00 00 12345000 1 1
FFFFF497 00001040 0 02 09 00 00 FFFFF000 1 1
00000000 00001044 3 00 00 00 00 00000000 0 0
00E6E633 00001048 0 1B 0C 0D 0E 00000000 0 1
FFFFFFFF 0000104C 3 00 00 00 00 00000000 0 0
0640B793 00001050 0 17 0F 01 00 00000064 1 1
800F9803 00001054 1 0C 10 1F 00 FFFFF800 1 1
00010023 00001058 1 10 00 02 00 00000000 0 0
003170B3 0000105C 0 1C 01 02 03 00000000 0 1

// ==== sim.f ====
common/rv_pkg.sv
rtl/inst_decoder.sv
op_queue/fetched_op_queue.sv
rtl/issue_router.sv
rtl/decode_issue_top.sv
verif/decode_issue_assertions.sv
verif/tb_decode_issue.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_decode_issue
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf $(OBJ_DIR)
